//--- hw/execPkg.sv
//--------------------------------------------------------------------------
// Shared execute stage types with the word type, decoded operation enum,
// PC constants and MIPS opcode, funct and rt field encodings
//--------------------------------------------------------------------------

package execPkg;

    typedef logic [31:0] wordT;  // Operands, results, addresses
    typedef logic [5:0]  opcT;   // Opcode and funct fields
    typedef logic [4:0]  regT;   // rt field of REGIMM

    // Decoded operations
    typedef enum logic [5:0]
    {
        OP_NOP, OP_J, OP_JAL,
        OP_BEQ, OP_BNE, OP_BGEZ, OP_BGEZAL, OP_BGTZ, OP_BLEZ, OP_BLTZ, OP_BLTZAL,
        OP_ADDU, OP_SUBU, OP_AND, OP_OR, OP_XOR, OP_SLT, OP_ADDIU
    } opFuncT;

    localparam wordT RESET_PC   = 32'h0040_0000;
    localparam wordT PC_STEP    = 32'd4;
    localparam wordT RET_OFFSET = 32'd8;   // Return lands past the following slot

    //----------------------------------------------------------------------
    // Instruction field encodings
    //----------------------------------------------------------------------
    localparam opcT OPC_SPECIAL = 6'h00;
    localparam opcT OPC_REGIMM  = 6'h01;
    localparam opcT OPC_J       = 6'h02;
    localparam opcT OPC_JAL     = 6'h03;
    localparam opcT OPC_BEQ     = 6'h04;
    localparam opcT OPC_BNE     = 6'h05;
    localparam opcT OPC_BLEZ    = 6'h06;
    localparam opcT OPC_BGTZ    = 6'h07;
    localparam opcT OPC_ADDIU   = 6'h09;

    // funct values under SPECIAL
    localparam opcT FN_ADDU     = 6'h21;
    localparam opcT FN_SUBU     = 6'h23;
    localparam opcT FN_AND      = 6'h24;
    localparam opcT FN_OR       = 6'h25;
    localparam opcT FN_XOR      = 6'h26;
    localparam opcT FN_SLT      = 6'h2a;

    // rt values under REGIMM
    localparam regT RT_BLTZ     = 5'h00;
    localparam regT RT_BGEZ     = 5'h01;
    localparam regT RT_BLTZAL   = 5'h10;
    localparam regT RT_BGEZAL   = 5'h11;

endpackage

//--- hw/execBus.sv
//--------------------------------------------------------------------------
// Decoded operation bus from the decoder to the branch unit and the ALU
//--------------------------------------------------------------------------

interface execBus
    import execPkg::*;
();

    logic   enable;  // Decoded instruction present
    opFuncT func;
    wordT   offset;  // Sign-extended immediate or jump index
    logic   useImm;  // ALU second operand is offset

    modport decoder
    (
        output enable, func, offset, useImm
    );

    modport branch
    (
        input enable, func, offset
    );

    modport alu
    (
        input enable, func, offset, useImm
    );

endinterface

//--- hw/instrDecoder.sv
//--------------------------------------------------------------------------
// Instruction decoder turning opcode, funct and rt fields into an
// operation code, offset and ALU operand select
//--------------------------------------------------------------------------

module instrDecoder
    import execPkg::*;
(
    input  logic  instrValid,
    input  wordT  instr,
    execBus.decoder bus
);

    opcT opcode;
    opcT funct;
    regT rt;

    assign opcode = instr[31:26];
    assign rt     = instr[20:16];
    assign funct  = instr[5:0];

    assign bus.enable = instrValid;

    //----------------------------------------------------------------------
    // Operation select
    //----------------------------------------------------------------------
    always_comb
    begin
        bus.func = OP_NOP;  // Unknown encodings fall through to NOP

        case (opcode)
            OPC_SPECIAL:
                case (funct)
                    FN_ADDU: bus.func = OP_ADDU;
                    FN_SUBU: bus.func = OP_SUBU;
                    FN_AND:  bus.func = OP_AND;
                    FN_OR:   bus.func = OP_OR;
                    FN_XOR:  bus.func = OP_XOR;
                    FN_SLT:  bus.func = OP_SLT;
                    default: bus.func = OP_NOP;
                endcase

            OPC_REGIMM:
                case (rt)
                    RT_BLTZ:   bus.func = OP_BLTZ;
                    RT_BGEZ:   bus.func = OP_BGEZ;
                    RT_BLTZAL: bus.func = OP_BLTZAL;
                    RT_BGEZAL: bus.func = OP_BGEZAL;
                    default:   bus.func = OP_NOP;
                endcase

            OPC_J:     bus.func = OP_J;
            OPC_JAL:   bus.func = OP_JAL;
            OPC_BEQ:   bus.func = OP_BEQ;
            OPC_BNE:   bus.func = OP_BNE;
            OPC_BLEZ:  bus.func = OP_BLEZ;
            OPC_BGTZ:  bus.func = OP_BGTZ;
            OPC_ADDIU: bus.func = OP_ADDIU;
            default:   bus.func = OP_NOP;
        endcase
    end

    //----------------------------------------------------------------------
    // Offset and operand select
    //----------------------------------------------------------------------
    always_comb
    begin
        if (opcode == OPC_J || opcode == OPC_JAL)
        begin
            bus.offset = {6'b0, instr[25:0]};  // Zero-extended jump index
        end
        else
        begin
            bus.offset = {{16{instr[15]}}, instr[15:0]};
        end
    end

    assign bus.useImm = (bus.func == OP_ADDIU);

endmodule

//--- hw/branchUnit.sv
//--------------------------------------------------------------------------
// Branch unit for jump and branch resolution, next PC and return address
//--------------------------------------------------------------------------

module branchUnit
    import execPkg::*;
(
    input  wordT pcIn,
    input  wordT a,
    input  wordT b,
    execBus.branch bus,
    output wordT pcOut,
    output wordT ret,
    output logic taken
);

    wordT jumpTarget;
    wordT branchTarget;
    logic aNeg;
    logic aZero;
    logic cond;

    assign jumpTarget   = {pcIn[31:28], bus.offset[25:0], 2'b00};
    assign branchTarget = pcIn + {bus.offset[29:0], 2'b00};

    assign aNeg  = a[31];        // Sign of a
    assign aZero = (a == '0);

    //----------------------------------------------------------------------
    // Condition per operation
    //----------------------------------------------------------------------
    always_comb
    begin
        cond = 1'b0;

        if (bus.enable)
        begin
            case (bus.func)
                OP_J,
                OP_JAL:    cond = 1'b1;
                OP_BEQ:    cond = (a == b);
                OP_BNE:    cond = (a != b);
                OP_BGEZ,
                OP_BGEZAL: cond = !aNeg;
                OP_BGTZ:   cond = !aNeg && !aZero;
                OP_BLEZ:   cond = aNeg || aZero;
                OP_BLTZ,
                OP_BLTZAL: cond = aNeg;
                default:   cond = 1'b0;
            endcase
        end
    end

    //----------------------------------------------------------------------
    // Next PC
    //----------------------------------------------------------------------
    always_comb
    begin
        taken = cond;
        pcOut = pcIn + PC_STEP;  // Sequential step when nothing is taken

        if (cond)
        begin
            if (bus.func == OP_J || bus.func == OP_JAL)
                pcOut = jumpTarget;
            else
                pcOut = branchTarget;
        end
    end

    assign ret = pcIn + RET_OFFSET;

endmodule

//--- hw/aluUnit.sv
//--------------------------------------------------------------------------
// Integer ALU for register and immediate forms
//--------------------------------------------------------------------------

module aluUnit
    import execPkg::*;
(
    input  wordT a,
    input  wordT b,
    execBus.alu  bus,
    output wordT y
);

    wordT bOp;
    logic lessThan;

    // Second operand select
    assign bOp = bus.useImm ? bus.offset : b;

    assign lessThan = ($signed(a) < $signed(bOp));

    //----------------------------------------------------------------------
    // Operation
    //----------------------------------------------------------------------
    always_comb
    begin
        y = '0;  // Non-ALU operations give zero

        if (bus.enable)
        begin
            case (bus.func)
                OP_ADDU,
                OP_ADDIU:
                begin
                    y = a + bOp;
                end

                OP_SUBU:
                begin
                    y = a - bOp;
                end

                OP_AND:
                begin
                    y = a & bOp;
                end

                OP_OR:
                begin
                    y = a | bOp;
                end

                OP_XOR:
                begin
                    y = a ^ bOp;
                end

                OP_SLT:
                begin
                    y = {31'b0, lessThan};  // Signed compare
                end

                default:
                begin
                    y = '0;
                end
            endcase
        end
    end

endmodule

//--- hw/pcSequencer.sv
//--------------------------------------------------------------------------
// Program counter register with reset vector and next PC load
//--------------------------------------------------------------------------

module pcSequencer
    import execPkg::*;
(
    input  logic clk,
    input  logic rstN,
    input  logic advance,  // Instruction retired this cycle
    input  wordT nextPc,
    output wordT pc
);

    wordT pcReg;

    //----------------------------------------------------------------------
    // PC state
    //----------------------------------------------------------------------
    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            pcReg <= RESET_PC;
        end
        else if (advance)
        begin
            pcReg <= nextPc;  // Step or redirect resolved upstream
        end
    end

    // Holds while idle
    assign pc = pcReg;

endmodule

//--- hw/execTop.sv
//--------------------------------------------------------------------------
// Execute stage top with decoder, branch unit, ALU, PC sequencer and the
// registered stage outputs
//--------------------------------------------------------------------------

module execTop
    import execPkg::*;
(
    input  logic clk,
    input  logic rstN,
    input  logic instrValid,  // One-cycle strobe
    input  wordT instr,
    input  wordT opA,
    input  wordT opB,
    output wordT pc,
    output wordT result,
    output logic resultValid,
    output logic taken,
    output logic linkWrite
);

    wordT nextPc;
    wordT retAddr;
    wordT aluY;
    logic brTaken;
    logic isLink;

    execBus bus_i ();

    instrDecoder decoder_i (.instrValid(instrValid), .instr(instr), .bus(bus_i.decoder));

    branchUnit branch_i
    (
        .pcIn  (pc),
        .a     (opA),
        .b     (opB),
        .bus   (bus_i.branch),
        .pcOut (nextPc),
        .ret   (retAddr),
        .taken (brTaken)
    );

    aluUnit alu_i (.a(opA), .b(opB), .bus(bus_i.alu), .y(aluY));

    pcSequencer pcSeq_i (.clk(clk), .rstN(rstN), .advance(instrValid), .nextPc(nextPc), .pc(pc));

    // Link operations write the return address
    assign isLink = bus_i.enable && (bus_i.func == OP_JAL || bus_i.func == OP_BGEZAL ||
                                     bus_i.func == OP_BLTZAL);

    //----------------------------------------------------------------------
    // Output register
    //----------------------------------------------------------------------
    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            result      <= '0;
            resultValid <= 1'b0;
            taken       <= 1'b0;
            linkWrite   <= 1'b0;
        end
        else
        begin
            result      <= isLink ? retAddr : aluY;  // aluY is zero for non-ALU ops
            resultValid <= instrValid;
            taken       <= brTaken;
            linkWrite   <= isLink;
        end
    end

endmodule

//--- tb/execTopTb.sv
//--------------------------------------------------------------------------
// Testbench for the execute stage with clock, reset, random instructions,
// reference model, output checks and watchdog
//--------------------------------------------------------------------------

module execTopTb
    import execPkg::*;
();

    localparam int CLK_PERIOD = 40;
    localparam int NUM_ITER   = 400;                           // Instructions plus idle cycles
    localparam int TIMEOUT    = (NUM_ITER * 2 + 20) * CLK_PERIOD;

    logic clk;
    logic rstN;
    logic instrValid;
    wordT instr;
    wordT opA;
    wordT opB;
    wordT pc;
    wordT result;
    logic resultValid;
    logic taken;
    logic linkWrite;

    integer seed;
    wordT   modelPc;     // Model copy of the architectural PC
    wordT   expPc;
    wordT   expResult;
    logic   expTaken;
    logic   expLink;

    execTop dut_i
    (
        .clk         (clk),
        .rstN        (rstN),
        .instrValid  (instrValid),
        .instr       (instr),
        .opA         (opA),
        .opB         (opB),
        .pc          (pc),
        .result      (result),
        .resultValid (resultValid),
        .taken       (taken),
        .linkWrite   (linkWrite)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    //----------------------------------------------------------------------
    // Compare and report
    //----------------------------------------------------------------------
    task automatic checkValue(input string name, input wordT got, input wordT exp);
        if (got !== exp)
        begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            $display("Something failed");
            $fatal(1);
        end
    endtask

    // Random instruction and operands, applied on the falling edge
    task automatic makeStimulus(output logic valid);
        int unsigned pick;
        int unsigned sel;
        wordT        raw;
        raw  = $random(seed);        // Random register fields and immediate
        pick = $unsigned($random(seed)) % 16;
        sel  = $unsigned($random(seed)) % 4;
        valid = 1'b1;
        case (pick)
            0, 1:    valid = 1'b0;                               // Idle cycle with garbage on instr
            2, 3, 4, 5:
            begin
                raw[31:26] = OPC_SPECIAL;
                case ($unsigned($random(seed)) % 6)
                    0:       raw[5:0] = FN_ADDU;
                    1:       raw[5:0] = FN_SUBU;
                    2:       raw[5:0] = FN_AND;
                    3:       raw[5:0] = FN_OR;
                    4:       raw[5:0] = FN_XOR;
                    default: raw[5:0] = FN_SLT;
                endcase
            end
            6:       raw[31:26] = OPC_ADDIU;
            7:       raw[31:26] = OPC_BEQ;
            8:       raw[31:26] = OPC_BNE;
            9:       raw[31:26] = (raw[0]) ? OPC_BLEZ : OPC_BGTZ;
            10, 11:
            begin
                raw[31:26] = OPC_REGIMM;
                case ($unsigned($random(seed)) % 4)
                    0:       raw[20:16] = RT_BLTZ;
                    1:       raw[20:16] = RT_BGEZ;
                    2:       raw[20:16] = RT_BLTZAL;
                    default: raw[20:16] = RT_BGEZAL;
                endcase
            end
            12:
            begin
                raw[31:26] = OPC_J;
                if (sel[1])
                    raw[25:14] = '0;                               // Low target so a branch can wrap
            end
            13:      raw[31:26] = OPC_JAL;
            14:      raw[31:26] = (sel[0]) ? 6'h3f : 6'h08;     // Undecoded opcodes
            default:
            begin
                // Undecoded funct under SPECIAL, or undecoded rt under REGIMM
                if (sel[1])
                begin
                    raw[31:26] = OPC_SPECIAL;
                    raw[5:0]   = 6'h20;
                end
                else
                begin
                    raw[31:26] = OPC_REGIMM;
                    raw[20:16] = 5'h02;
                end
            end
        endcase
        instr = raw;
        opA   = $random(seed);
        opB   = $random(seed);
        if (sel == 0)
            opA = '0;                                              // Zero edge for compares
        else if (sel == 1)
            opB = opA;                                             // Equal operands
    endtask

    //----------------------------------------------------------------------
    // Reference model
    //----------------------------------------------------------------------
    task automatic predict(input wordT ins, input wordT a, input wordT b);
        opcT  opc;
        opcT  fn;
        regT  rt;
        wordT imm;
        logic cond;
        logic isJump;
        opc    = ins[31:26];
        fn     = ins[5:0];
        rt     = ins[20:16];
        imm    = {{16{ins[15]}}, ins[15:0]};
        cond   = 1'b0;
        isJump = 1'b0;
        expLink   = 1'b0;
        expResult = '0;
        case (opc)
            OPC_SPECIAL:
                case (fn)
                    FN_ADDU: expResult = a + b;
                    FN_SUBU: expResult = a - b;
                    FN_AND:  expResult = a & b;
                    FN_OR:   expResult = a | b;
                    FN_XOR:  expResult = a ^ b;
                    FN_SLT:  expResult = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default: expResult = '0;
                endcase
            OPC_ADDIU: expResult = a + imm;
            OPC_J:     isJump = 1'b1;
            OPC_JAL:
            begin
                isJump  = 1'b1;
                expLink = 1'b1;
            end
            OPC_BEQ:   cond = (a == b);
            OPC_BNE:   cond = (a != b);
            OPC_BLEZ:  cond = ($signed(a) <= 32'sd0);
            OPC_BGTZ:  cond = ($signed(a) > 32'sd0);
            OPC_REGIMM:
            begin
                if (rt == RT_BLTZ || rt == RT_BLTZAL)
                    cond = ($signed(a) < 32'sd0);
                else if (rt == RT_BGEZ || rt == RT_BGEZAL)
                    cond = ($signed(a) >= 32'sd0);
                expLink = (rt == RT_BLTZAL || rt == RT_BGEZAL);
            end
            default:   cond = 1'b0;                                // Behaves as NOP
        endcase
        if (expLink)
            expResult = modelPc + RET_OFFSET;                      // Written even if not taken
        expTaken = isJump || cond;
        if (isJump)
            expPc = {modelPc[31:28], ins[25:0], 2'b00};
        else if (cond)
            expPc = modelPc + (imm << 2);
        else
            expPc = modelPc + PC_STEP;
    endtask

    // Watchdog
    initial
    begin
        #(TIMEOUT);
        $display("Timeout: the test did not finish within the expected time");
        $display("Something failed");
        $fatal(1);
    end

    //----------------------------------------------------------------------
    // Main sequence
    //----------------------------------------------------------------------
    initial
    begin
        logic valid;
        seed       = 32'hac78_c2b3;
        clk        = 1'b0;
        rstN       = 1'b0;
        instrValid = 1'b0;
        instr      = '0;
        opA        = '0;
        opB        = '0;
        modelPc    = RESET_PC;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;

        // State straight after reset
        checkValue("pc", pc, RESET_PC);
        checkValue("resultValid", resultValid, 1'b0);
        checkValue("taken", taken, 1'b0);
        checkValue("linkWrite", linkWrite, 1'b0);
        checkValue("result", result, '0);

        for (int i = 0; i < NUM_ITER; i++)
        begin
            makeStimulus(valid);
            instrValid = valid;
            if (valid)
            begin
                predict(instr, opA, opB);
            end
            else
            begin
                expPc     = modelPc;                               // Idle holds the PC
                expResult = '0;
                expTaken  = 1'b0;
                expLink   = 1'b0;
            end
            @(negedge clk);                                        // Outputs settled after posedge
            checkValue("resultValid", resultValid, valid);
            checkValue("pc", pc, expPc);
            checkValue("result", result, expResult);
            checkValue("taken", taken, expTaken);
            checkValue("linkWrite", linkWrite, expLink);
            modelPc = expPc;
        end
        instrValid = 1'b0;

        $display("Everything OK");
        $finish;
    end

endmodule

//--- execStage.f
hw/execPkg.sv
hw/execBus.sv
hw/instrDecoder.sv
hw/branchUnit.sv
hw/aluUnit.sv
hw/pcSequencer.sv
hw/execTop.sv
tb/execTopTb.sv
